// ==== filelist.f ====
hw/params_pkg.sv
hw/dcache_if.sv
hw/tlb.sv
hw/ptw.sv
hw/data_cache.sv
hw/mem_stage.sv
hw/mem_subsys_top.sv
tests/mem_subsys_sva.sv
tests/tb_mem_subsys.sv

// ==== hw/data_cache.sv ====
`timescale 1ns/10ps

module data_cache #(
  parameter int CACHE_LINE_BYTES = 16,
  parameter int DCACHE_N_LINES   = 4
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  dcache_if.cache                            cpu,
  input  logic                               flush_req_i,
  output logic                               flush_done_o,
  output logic                               mem_req_o,
  output logic                               mem_we_o,
  output logic [params_pkg::PADDR_WIDTH-1:0] mem_addr_o,
  output logic [CACHE_LINE_BYTES*8-1:0]      mem_wdata_o,
  input  logic                               mem_gnt_i,
  input  logic                               mem_rvalid_i,
  input  logic [CACHE_LINE_BYTES*8-1:0]      mem_rdata_i,
  input  logic                               mem_write_done_i
);

  localparam int OFF_W = $clog2(CACHE_LINE_BYTES);
  localparam int IDX_W = $clog2(DCACHE_N_LINES);
  localparam int TAG_W = params_pkg::PADDR_WIDTH - OFF_W - IDX_W;

  params_pkg::cache_state_t        state_q;
  logic [TAG_W-1:0]                tag_q  [DCACHE_N_LINES];
  logic [CACHE_LINE_BYTES*8-1:0]   line_q [DCACHE_N_LINES];
  logic [DCACHE_N_LINES-1:0]       valid_q;
  logic [DCACHE_N_LINES-1:0]       dirty_q;
  logic [IDX_W-1:0]                idx_q;       // Line being evicted, refilled or flushed
  logic [TAG_W-1:0]                miss_tag_q;
  logic                            granted_q;
  logic                            flush_pend_q;
  logic                            tag_match;
  logic                            store_hit;
  logic                            flush_go;
  logic                            start_miss;
  logic                            last_line;
  logic [31:0]                     rd_word;
  logic [3:0]                      rd_mask;

  assign tag_match  = valid_q[cpu.index] && tag_q[cpu.index] == cpu.tag;
  assign cpu.hit    = cpu.req && tag_match && state_q == params_pkg::C_IDLE;
  assign cpu.rvalid = cpu.hit && !cpu.wr;
  assign store_hit  = cpu.hit && cpu.wr;
  assign flush_go   = flush_pend_q || flush_req_i;
  assign start_miss = state_q == params_pkg::C_IDLE && cpu.req && !tag_match && !flush_go;
  assign last_line  = idx_q == IDX_W'(DCACHE_N_LINES - 1);

  // Lanes outside the access read as zero
  assign rd_word = line_q[cpu.index][cpu.word*32 +: 32];
  assign rd_mask = params_pkg::lane_mask(cpu.size, cpu.addr[1:0]);

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      cpu.rdata[8*b +: 8] = rd_mask[b] ? rd_word[8*b +: 8] : 8'h00;
    end
  end

  assign mem_req_o = !granted_q && (state_q == params_pkg::C_EVICT ||
                                    state_q == params_pkg::C_REFILL ||
                                    state_q == params_pkg::C_FLUSH_WR);
  assign mem_we_o    = mem_req_o && state_q != params_pkg::C_REFILL;
  assign mem_addr_o  = {(state_q == params_pkg::C_REFILL) ? miss_tag_q : tag_q[idx_q],
                        idx_q, OFF_W'(0)};
  assign mem_wdata_o = line_q[idx_q];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q      <= params_pkg::C_IDLE;
      valid_q      <= '0;
      dirty_q      <= '0;
      idx_q        <= '0;
      granted_q    <= 1'b0;
      flush_pend_q <= 1'b0;
      flush_done_o <= 1'b0;
    end else begin
      flush_done_o <= 1'b0;
      if (mem_req_o && mem_gnt_i) granted_q <= 1'b1;
      if (flush_req_i) flush_pend_q <= 1'b1;
      case (state_q)
        params_pkg::C_IDLE: begin
          if (store_hit) dirty_q[cpu.index] <= 1'b1;
          if (flush_go) begin
            flush_pend_q <= 1'b0;
            idx_q        <= '0;
            state_q      <= params_pkg::C_FLUSH_SCAN;
          end else if (start_miss) begin
            idx_q   <= cpu.index;
            state_q <= (valid_q[cpu.index] && dirty_q[cpu.index]) ?
                       params_pkg::C_EVICT : params_pkg::C_REFILL;
          end
        end
        params_pkg::C_EVICT: begin
          if (mem_write_done_i) begin
            granted_q      <= 1'b0;
            dirty_q[idx_q] <= 1'b0;
            state_q        <= params_pkg::C_REFILL;
          end
        end
        params_pkg::C_REFILL: begin
          if (mem_rvalid_i) begin
            granted_q      <= 1'b0;
            valid_q[idx_q] <= 1'b1;
            dirty_q[idx_q] <= 1'b0;
            state_q        <= params_pkg::C_IDLE;
          end
        end
        params_pkg::C_FLUSH_SCAN: begin
          if (valid_q[idx_q] && dirty_q[idx_q]) begin
            state_q <= params_pkg::C_FLUSH_WR;
          end else if (last_line) begin
            flush_done_o <= 1'b1;
            state_q      <= params_pkg::C_IDLE;
          end else begin
            idx_q <= idx_q + 1'b1;
          end
        end
        params_pkg::C_FLUSH_WR: begin
          if (mem_write_done_i) begin
            granted_q      <= 1'b0;
            dirty_q[idx_q] <= 1'b0;  // Line stays valid
            if (last_line) begin
              flush_done_o <= 1'b1;
              state_q      <= params_pkg::C_IDLE;
            end else begin
              idx_q   <= idx_q + 1'b1;
              state_q <= params_pkg::C_FLUSH_SCAN;
            end
          end
        end
        default: state_q <= params_pkg::C_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_miss) miss_tag_q <= cpu.tag;
    if (state_q == params_pkg::C_REFILL && mem_rvalid_i) begin
      line_q[idx_q] <= mem_rdata_i;
      tag_q[idx_q]  <= miss_tag_q;
    end
    if (store_hit) begin
      for (int b = 0; b < 4; b++) begin
        if (cpu.wstrb[b]) line_q[cpu.index][cpu.word*32 + 8*b +: 8] <= cpu.wdata[8*b +: 8];
      end
    end
  end

endmodule

// ==== hw/dcache_if.sv ====
`timescale 1ns/10ps

interface dcache_if #(
  parameter int CACHE_LINE_BYTES = 16,
  parameter int DCACHE_N_LINES   = 4
);

  localparam int OFF_W = $clog2(CACHE_LINE_BYTES);
  localparam int IDX_W = $clog2(DCACHE_N_LINES);
  localparam int TAG_W = params_pkg::PADDR_WIDTH - OFF_W - IDX_W;

  logic                                 req;
  logic                                 wr;
  logic [params_pkg::PADDR_WIDTH-1:0]   addr;
  logic [params_pkg::DATA_WIDTH-1:0]    wdata;
  logic [3:0]                           wstrb;
  params_pkg::access_size_t             size;
  logic                                 hit;
  logic                                 rvalid;
  logic [params_pkg::DATA_WIDTH-1:0]    rdata;

  // Address split as the cache sees it
  logic [TAG_W-1:0]   tag;
  logic [IDX_W-1:0]   index;
  logic [OFF_W-3:0]   word;

  assign tag   = addr[params_pkg::PADDR_WIDTH-1 -: TAG_W];
  assign index = addr[OFF_W +: IDX_W];
  assign word  = addr[OFF_W-1:2];

  modport cpu (output req, wr, addr, wdata, wstrb, size, input hit, rvalid, rdata);

  modport cache (
    input  req, wr, addr, wdata, wstrb, size, tag, index, word,
    output hit, rvalid, rdata
  );

endinterface

// ==== hw/mem_stage.sv ====
`timescale 1ns/10ps

module mem_stage (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  vm_en_i,
  input  logic                                  trap_bypass_mmu_i,
  input  logic                                  flush_i,
  input  logic                                  valid_i,
  input  logic                                  is_load_i,
  input  logic                                  is_store_i,
  input  logic                                  reg_wr_en_i,
  input  params_pkg::access_size_t              access_size_i,
  input  logic [params_pkg::ADDR_WIDTH-1:0]     alu_result_i,
  input  logic [params_pkg::DATA_WIDTH-1:0]     rs2_data_i,
  input  logic [params_pkg::REGISTER_WIDTH-1:0] wr_reg_i,
  input  logic [params_pkg::DATA_WIDTH-1:0]     satp_data_i,
  dcache_if.cpu                                 cpu,
  input  logic                                  tlb_hit_i,
  input  logic [params_pkg::PPN_WIDTH-1:0]      tlb_ppn_i,
  output logic                                  tlb_wr_en_o,
  output logic                                  ptw_req_o,
  input  logic                                  ptw_valid_i,
  input  logic                                  ptw_error_i,
  input  logic [params_pkg::PADDR_WIDTH-1:0]    ptw_paddr_i,
  output logic                                  wb_valid_o,
  output logic                                  wb_excpt_o,
  output params_pkg::excpt_cause_t              wb_excpt_cause_o,
  output logic [params_pkg::ADDR_WIDTH-1:0]     wb_excpt_tval_o,
  output logic                                  wb_reg_wr_en_o,
  output logic [params_pkg::REGISTER_WIDTH-1:0] wb_wr_reg_o,
  output logic [params_pkg::DATA_WIDTH-1:0]     wb_data_o,
  output logic                                  stall_o
);

  params_pkg::stage_state_t           state_q;
  params_pkg::stage_state_t           state_d;
  logic [params_pkg::PADDR_WIDTH-1:0] paddr;
  logic [params_pkg::PADDR_WIDTH-1:0] paddr_q;  // Held across a miss
  logic                               mmu_en;
  logic                               access;
  logic                               translate;
  logic                               done;
  logic [1:0]                         offset;

  // Sv32 mode bit must also be set
  assign mmu_en    = vm_en_i && satp_data_i[31] && !trap_bypass_mmu_i;
  assign access    = is_load_i || is_store_i;
  assign translate = state_q == params_pkg::READY && valid_i && access && !flush_i;
  assign offset    = alu_result_i[1:0];

  always_comb begin
    ptw_req_o   = 1'b0;
    tlb_wr_en_o = 1'b0;
    paddr       = alu_result_i[params_pkg::PADDR_WIDTH-1:0];
    if (mmu_en) begin
      if (tlb_hit_i) begin
        paddr = {tlb_ppn_i, alu_result_i[11:0]};
      end else begin
        ptw_req_o   = translate;
        paddr       = ptw_paddr_i;
        tlb_wr_en_o = ptw_valid_i;  // Refill TLB from the walk
      end
    end
  end

  assign cpu.addr  = (state_q == params_pkg::READY) ? paddr : paddr_q;
  assign cpu.wr    = is_store_i && !flush_i && state_q != params_pkg::FLUSH;
  assign cpu.size  = access_size_i;
  assign cpu.wstrb = params_pkg::lane_mask(access_size_i, offset);

  always_comb begin
    case (access_size_i)
      params_pkg::BYTE: cpu.wdata = {4{rs2_data_i[7:0]}};
      params_pkg::HALF: cpu.wdata = {2{rs2_data_i[15:0]}};
      default:          cpu.wdata = rs2_data_i;
    endcase
  end

  assign done = cpu.rvalid || (cpu.wr && cpu.hit);

  always_comb begin
    state_d        = state_q;
    stall_o        = 1'b0;
    wb_valid_o     = 1'b0;
    wb_reg_wr_en_o = 1'b0;
    cpu.req        = 1'b0;
    case (state_q)
      params_pkg::IDLE: state_d = params_pkg::READY;
      params_pkg::READY: begin
        if (valid_i && !flush_i) begin
          if (ptw_error_i) begin
            wb_valid_o = 1'b1;
          end else if (!access) begin
            wb_valid_o     = 1'b1;
            wb_reg_wr_en_o = reg_wr_en_i;
          end else begin
            cpu.req = 1'b1;
            if (done) begin
              wb_valid_o     = 1'b1;
              wb_reg_wr_en_o = is_load_i || reg_wr_en_i;
            end else begin
              stall_o = 1'b1;
              state_d = params_pkg::WAITING;
            end
          end
        end
      end
      params_pkg::WAITING: begin
        cpu.req = 1'b1;
        stall_o = 1'b1;
        if (flush_i) begin
          state_d = params_pkg::FLUSH;
        end else if (done) begin
          stall_o        = 1'b0;
          wb_valid_o     = 1'b1;
          wb_reg_wr_en_o = is_load_i || reg_wr_en_i;
          state_d        = params_pkg::READY;
        end
      end
      default: begin
        // Read the same line until the refill lands, then drop it
        cpu.req = 1'b1;
        stall_o = !cpu.rvalid;
        if (cpu.rvalid) state_d = params_pkg::READY;
      end
    endcase
  end

  assign wb_excpt_o       = ptw_error_i;
  assign wb_excpt_cause_o = !ptw_error_i ? params_pkg::NONE :
                            is_load_i ? params_pkg::LOAD_PAGE_FAULT :
                            params_pkg::STORE_PAGE_FAULT;
  assign wb_excpt_tval_o  = ptw_error_i ? alu_result_i : '0;
  assign wb_wr_reg_o      = wr_reg_i;
  // Cache zeroes unused lanes so the shift also zero-extends
  assign wb_data_o        = is_load_i ? cpu.rdata >> {offset, 3'b000} : alu_result_i;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q <= params_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == params_pkg::READY) paddr_q <= paddr;
  end

endmodule

// ==== hw/mem_subsys_top.sv ====
`timescale 1ns/10ps

module mem_subsys_top #(
  parameter int CACHE_LINE_BYTES = 16,
  parameter int DCACHE_N_LINES   = 4,
  parameter int TLB_ENTRIES      = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  vm_en_i,
  input  logic                                  trap_bypass_mmu_i,
  input  logic                                  flush_i,
  input  logic                                  valid_i,
  input  logic                                  is_load_i,
  input  logic                                  is_store_i,
  input  logic                                  reg_wr_en_i,
  input  params_pkg::access_size_t              access_size_i,
  input  logic [params_pkg::ADDR_WIDTH-1:0]     alu_result_i,
  input  logic [params_pkg::DATA_WIDTH-1:0]     rs2_data_i,
  input  logic [params_pkg::REGISTER_WIDTH-1:0] wr_reg_i,
  input  logic [params_pkg::DATA_WIDTH-1:0]     satp_data_i,
  output logic                                  wb_valid_o,
  output logic                                  wb_excpt_o,
  output params_pkg::excpt_cause_t              wb_excpt_cause_o,
  output logic [params_pkg::ADDR_WIDTH-1:0]     wb_excpt_tval_o,
  output logic                                  wb_reg_wr_en_o,
  output logic [params_pkg::REGISTER_WIDTH-1:0] wb_wr_reg_o,
  output logic [params_pkg::DATA_WIDTH-1:0]     wb_data_o,
  output logic                                  stall_o,
  output logic                                  rd_req_valid_o,
  output logic                                  wr_req_valid_o,
  output logic [params_pkg::PADDR_WIDTH-1:0]    mem_req_address_o,
  output logic [CACHE_LINE_BYTES*8-1:0]         wr_line_data_o,
  input  logic                                  mem_gnt_i,
  input  logic                                  mem_rvalid_i,
  input  logic [CACHE_LINE_BYTES*8-1:0]         mem_line_data_i,
  input  logic                                  mem_write_done_i,
  output logic                                  present_table_req_o,
  output logic [params_pkg::PPN_WIDTH-1:0]      present_table_ppn_o,
  input  logic                                  ppn_is_present_i,
  input  logic                                  flush_req_i,
  output logic                                  flush_done_o
);

  logic                               tlb_hit;
  logic                               tlb_wr_en;
  logic [params_pkg::PPN_WIDTH-1:0]   tlb_ppn;
  logic                               ptw_req;
  logic                               ptw_valid;
  logic                               ptw_error;
  logic [params_pkg::PADDR_WIDTH-1:0] ptw_paddr;
  logic                               cache_mem_req;

  dcache_if #(
    .CACHE_LINE_BYTES (CACHE_LINE_BYTES),
    .DCACHE_N_LINES   (DCACHE_N_LINES)
  ) dc_bus ();

  mem_stage u_mem_stage (
    .clk_i, .rst_i, .vm_en_i, .trap_bypass_mmu_i, .flush_i, .valid_i,
    .is_load_i, .is_store_i, .reg_wr_en_i, .access_size_i, .alu_result_i,
    .rs2_data_i, .wr_reg_i, .satp_data_i,
    .cpu          (dc_bus.cpu),
    .tlb_hit_i    (tlb_hit),
    .tlb_ppn_i    (tlb_ppn),
    .tlb_wr_en_o  (tlb_wr_en),
    .ptw_req_o    (ptw_req),
    .ptw_valid_i  (ptw_valid),
    .ptw_error_i  (ptw_error),
    .ptw_paddr_i  (ptw_paddr),
    .wb_valid_o, .wb_excpt_o, .wb_excpt_cause_o, .wb_excpt_tval_o,
    .wb_reg_wr_en_o, .wb_wr_reg_o, .wb_data_o, .stall_o
  );

  tlb #(
    .TLB_ENTRIES (TLB_ENTRIES)
  ) u_tlb (
    .clk_i, .rst_i, .flush_i,
    .wr_en_i (tlb_wr_en),
    .vpn_i   (alu_result_i[31:12]),
    .ppn_i   (ptw_paddr[19:12]),
    .hit_o   (tlb_hit),
    .ppn_o   (tlb_ppn)
  );

  ptw u_ptw (
    .req_i            (ptw_req),
    .ppn_is_present_i,
    .vaddr_i          (alu_result_i),
    .satp_data_i,
    .valid_o          (ptw_valid),
    .error_o          (ptw_error),
    .paddr_o          (ptw_paddr),
    .present_ppn_o    (present_table_ppn_o),
    .present_req_o    (present_table_req_o)
  );

  data_cache #(
    .CACHE_LINE_BYTES (CACHE_LINE_BYTES),
    .DCACHE_N_LINES   (DCACHE_N_LINES)
  ) u_dcache (
    .clk_i, .rst_i,
    .cpu              (dc_bus.cache),
    .flush_req_i, .flush_done_o,
    .mem_req_o        (cache_mem_req),
    .mem_we_o         (wr_req_valid_o),
    .mem_addr_o       (mem_req_address_o),
    .mem_wdata_o      (wr_line_data_o),
    .mem_gnt_i,
    .mem_rvalid_i,
    .mem_rdata_i      (mem_line_data_i),
    .mem_write_done_i
  );

  assign rd_req_valid_o = cache_mem_req && !wr_req_valid_o;

endmodule

// ==== hw/params_pkg.sv ====
package params_pkg;

  localparam int DATA_WIDTH     = 32;
  localparam int ADDR_WIDTH     = 32;  // Virtual
  localparam int PADDR_WIDTH    = 20;
  localparam int PPN_WIDTH      = 8;
  localparam int VPN_WIDTH      = 20;
  localparam int REGISTER_WIDTH = 5;

  typedef enum logic [1:0] {
    BYTE,
    HALF,
    WORD
  } access_size_t;

  // RISC-V mcause codes
  typedef enum logic [3:0] {
    NONE             = 4'd0,
    LOAD_PAGE_FAULT  = 4'd13,
    STORE_PAGE_FAULT = 4'd15
  } excpt_cause_t;

  typedef enum logic [1:0] {
    IDLE,
    READY,
    WAITING,
    FLUSH
  } stage_state_t;

  typedef enum logic [2:0] {
    C_IDLE,
    C_EVICT,
    C_REFILL,
    C_FLUSH_SCAN,
    C_FLUSH_WR
  } cache_state_t;

  // Byte lanes touched by an access
  function automatic logic [3:0] lane_mask(access_size_t size, logic [1:0] offset);
    case (size)
      BYTE:    lane_mask = 4'b0001 << offset;
      HALF:    lane_mask = 4'b0011 << offset;
      default: lane_mask = 4'b1111;
    endcase
  endfunction

endpackage

// ==== hw/ptw.sv ====
`timescale 1ns/10ps

module ptw (
  input  logic                               req_i,
  input  logic                               ppn_is_present_i,
  input  logic [params_pkg::ADDR_WIDTH-1:0]  vaddr_i,
  input  logic [params_pkg::DATA_WIDTH-1:0]  satp_data_i,
  output logic                               valid_o,
  output logic                               error_o,
  output logic [params_pkg::PADDR_WIDTH-1:0] paddr_o,
  output logic [params_pkg::PPN_WIDTH-1:0]   present_ppn_o,
  output logic                               present_req_o
);

  logic [params_pkg::PPN_WIDTH-1:0] cand_ppn;

  // Single level, root PPN plus low VPN bits, wraps at 256
  assign cand_ppn = satp_data_i[params_pkg::PPN_WIDTH-1:0]
                  + vaddr_i[12 +: params_pkg::PPN_WIDTH];

  assign present_req_o = req_i;
  assign present_ppn_o = cand_ppn;
  assign paddr_o       = {cand_ppn, vaddr_i[11:0]};
  assign valid_o       = req_i && ppn_is_present_i;
  assign error_o       = req_i && !ppn_is_present_i;

endmodule

// ==== hw/tlb.sv ====
`timescale 1ns/10ps

module tlb #(
  parameter int TLB_ENTRIES = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic                             flush_i,
  input  logic                             wr_en_i,
  input  logic [params_pkg::VPN_WIDTH-1:0] vpn_i,
  input  logic [params_pkg::PPN_WIDTH-1:0] ppn_i,
  output logic                             hit_o,
  output logic [params_pkg::PPN_WIDTH-1:0] ppn_o
);

  localparam int PTR_W = $clog2(TLB_ENTRIES);

  logic [TLB_ENTRIES-1:0]             valid_q;
  logic [params_pkg::VPN_WIDTH-1:0]   vpn_q [TLB_ENTRIES];
  logic [params_pkg::PPN_WIDTH-1:0]   ppn_q [TLB_ENTRIES];
  logic [PTR_W-1:0]                   rr_q;  // Next victim

  always_comb begin
    hit_o = 1'b0;
    ppn_o = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (valid_q[i] && vpn_q[i] == vpn_i) begin
        hit_o = 1'b1;
        ppn_o = ppn_q[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q <= '0;
      rr_q    <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (wr_en_i) begin
      valid_q[rr_q] <= 1'b1;
      rr_q          <= rr_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en_i && !flush_i) begin
      vpn_q[rr_q] <= vpn_i;
      ppn_q[rr_q] <= ppn_i;
    end
  end

endmodule

// ==== tests/mem_subsys_sva.sv ====
`timescale 1ns/10ps

module mem_subsys_sva (
  input logic        clk_i,
  input logic        rst_i,
  input logic        rd_req_valid_o,
  input logic        wr_req_valid_o,
  input logic [19:0] mem_req_address_o,
  input logic        mem_gnt_i,
  input logic        stall_o,
  input logic        wb_valid_o,
  input logic        flush_done_o
);

  // Request and its address hold until granted
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
    ((rd_req_valid_o || wr_req_valid_o) && !mem_gnt_i) |=>
      ((rd_req_valid_o || wr_req_valid_o) && $stable(mem_req_address_o)))
    else $error("memory request dropped before grant");

  // A pending request keeps its direction
  a_dir_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
    ((rd_req_valid_o || wr_req_valid_o) && !mem_gnt_i) |=>
      ($stable(rd_req_valid_o) && $stable(wr_req_valid_o)))
    else $error("memory request changed direction before grant");

  a_stall_wb: assert property (@(posedge clk_i) disable iff (!rst_i)
    !(stall_o && wb_valid_o))
    else $error("stall and writeback valid together");

  a_flush_pulse: assert property (@(posedge clk_i) disable iff (!rst_i)
    flush_done_o |=> !flush_done_o)
    else $error("flush done held longer than one cycle");

endmodule

bind mem_subsys_top mem_subsys_sva u_sva (.*);

// ==== tests/tb_mem_subsys.sv ====
`timescale 1ns/10ps

module tb_mem_subsys;

  localparam int MEM_BYTES = 1 << 20;

  logic clk_i = 1'b0;
  logic rst_i;
  logic vm_en_i, trap_bypass_mmu_i, flush_i, valid_i, is_load_i, is_store_i, reg_wr_en_i;
  params_pkg::access_size_t access_size_i;
  logic [31:0] alu_result_i, rs2_data_i, satp_data_i;
  logic [4:0] wr_reg_i;
  logic wb_valid_o, wb_excpt_o, wb_reg_wr_en_o, stall_o;
  params_pkg::excpt_cause_t wb_excpt_cause_o;
  logic [31:0] wb_excpt_tval_o, wb_data_o;
  logic [4:0] wb_wr_reg_o;
  logic rd_req_valid_o, wr_req_valid_o, mem_gnt_i, mem_rvalid_i, mem_write_done_i;
  logic [19:0] mem_req_address_o;
  logic [127:0] wr_line_data_o, mem_line_data_i;
  logic present_table_req_o, ppn_is_present_i, flush_req_i, flush_done_o;
  logic [7:0] present_table_ppn_o;

  logic [7:0] mem [MEM_BYTES];      // Memory model
  logic [7:0] ref_mem [MEM_BYTES];  // Expected contents
  logic present [256];
  int seed = 32'h4ad8;
  int errors = 0;
  int timeouts = 0;
  int wr_count = 0;
  int walks = 0;
  int evt = 0;
  int last_wr_seq, last_rd_seq;
  logic [19:0] last_wr_addr, last_rd_addr;
  logic [127:0] last_wr_data;
  // Results of the last access
  logic [31:0] r_data, r_tval;
  logic r_excpt, r_regwr, r_first_stall;
  logic [4:0] r_wreg;
  int r_cyc, r_cause;

  mem_subsys_top DUT (.*);

  always #2 clk_i = ~clk_i;

  assign ppn_is_present_i = present[present_table_ppn_o];

  always @(posedge clk_i) if (present_table_req_o) walks++;

  function automatic logic [7:0] fill_byte(int a);
    fill_byte = 8'(a ^ (a >> 8) ^ (a >> 13) ^ 8'h5a);
  endfunction

  // Line memory with a random grant delay
  always begin
    int delay;
    logic we;
    logic [19:0] la;
    @(negedge clk_i);
    if (rst_i === 1'b1 && (rd_req_valid_o || wr_req_valid_o)) begin
      delay = $random(seed) & 3;
      repeat (delay) @(negedge clk_i);
      we = wr_req_valid_o;
      la = mem_req_address_o;
      mem_gnt_i = 1'b1;
      @(negedge clk_i);
      mem_gnt_i = 1'b0;
      evt++;
      if (we) begin
        for (int i = 0; i < 16; i++) mem[la + i] = wr_line_data_o[8*i +: 8];
        wr_count++;
        last_wr_addr = la;
        last_wr_data = wr_line_data_o;
        last_wr_seq  = evt;
        mem_write_done_i = 1'b1;
      end else begin
        for (int i = 0; i < 16; i++) mem_line_data_i[8*i +: 8] = mem[la + i];
        last_rd_addr = la;
        last_rd_seq  = evt;
        mem_rvalid_i = 1'b1;
      end
      @(negedge clk_i);
      mem_write_done_i = 1'b0;
      mem_rvalid_i     = 1'b0;
    end
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  function automatic logic [31:0] ref_load(input logic [19:0] pa, input int nbytes);
    ref_load = '0;
    for (int i = 0; i < nbytes; i++) ref_load[8*i +: 8] = ref_mem[pa + i];
  endfunction

  task automatic ref_store(input logic [19:0] pa, input int nbytes, input logic [31:0] d);
    for (int i = 0; i < nbytes; i++) ref_mem[pa + i] = d[8*i +: 8];
  endtask

  // One load or store, held until writeback
  task automatic access(input logic st, input params_pkg::access_size_t sz,
                        input logic [31:0] va, input logic [31:0] wd);
    @(negedge clk_i);
    valid_i = 1'b1;
    is_load_i = !st;
    is_store_i = st;
    reg_wr_en_i = !st;
    access_size_i = sz;
    alu_result_i = va;
    rs2_data_i = wd;
    wr_reg_i = va[6:2] ^ 5'h15;  // Varies per access
    r_cyc = 0;
    #1;
    r_first_stall = stall_o;
    while (!wb_valid_o && r_cyc < 300) begin
      @(negedge clk_i);
      #1;
      r_cyc++;
    end
    if (!wb_valid_o) begin
      $display("Timeout: no writeback for access to %h", va);
      timeouts++;
    end
    r_data = wb_data_o;
    r_excpt = wb_excpt_o;
    r_cause = wb_excpt_cause_o;
    r_tval = wb_excpt_tval_o;
    r_regwr = wb_reg_wr_en_o;
    r_wreg = wb_wr_reg_o;
    @(negedge clk_i);
    valid_i = 1'b0;
    is_load_i = 1'b0;
    is_store_i = 1'b0;
  endtask

  task automatic size_pair(input params_pkg::access_size_t sz, input int nb,
                           input logic [19:0] a, input logic [31:0] d);
    access(1'b1, sz, a, d);
    ref_store(a, nb, d);
    access(1'b0, sz, a, 0);
    check("store_sizes", ref_load(a, nb), r_data);
  endtask

  task automatic bare_load();
    vm_en_i = 1'b0;
    access(1'b0, params_pkg::WORD, 32'h100, 0);
    check("bare_load stall", 1, r_first_stall);
    check("bare_load miss", ref_load(20'h100, 4), r_data);
    check("bare_load regwr", 1, r_regwr);
    check("bare_load wr_reg", 5'h15, r_wreg);
    access(1'b0, params_pkg::WORD, 32'h104, 0);
    check("bare_load hit cycles", 0, r_cyc);
    check("bare_load hit", ref_load(20'h104, 4), r_data);
    check("bare_load hit wr_reg", 5'h14, r_wreg);
  endtask

  task automatic store_sizes();
    size_pair(params_pkg::BYTE, 1, 20'h101, 32'ha5);
    size_pair(params_pkg::HALF, 2, 20'h106, 32'hbeef);
    size_pair(params_pkg::WORD, 4, 20'h108, 32'h12345678);
    size_pair(params_pkg::BYTE, 1, 20'h10f, 32'h3c);
    for (int w = 0; w < 4; w++) begin
      access(1'b0, params_pkg::WORD, 32'h100 + 4 * w, 0);
      check("store_sizes neighbors", ref_load(20'h100 + 4 * w, 4), r_data);
    end
  endtask

  task automatic translate_and_fault();
    vm_en_i = 1'b1;
    satp_data_i = 32'h8000_0010;
    access(1'b0, params_pkg::WORD, 32'h3214, 0);  // PPN 0x10 + 0x03
    check("translate data", ref_load(20'h13214, 4), r_data);
    check("translate excpt", 0, r_excpt);
    check("translate regwr", 1, r_regwr);
    access(1'b0, params_pkg::WORD, 32'h5000, 0);
    check("load fault excpt", 1, r_excpt);
    check("load fault cause", 13, r_cause);
    check("load fault tval", 32'h5000, r_tval);
    check("load fault regwr", 0, r_regwr);
    access(1'b1, params_pkg::WORD, 32'h6008, 32'hdead);
    check("store fault excpt", 1, r_excpt);
    check("store fault cause", 15, r_cause);
    check("store fault tval", 32'h6008, r_tval);
    check("store fault regwr", 0, r_regwr);
    vm_en_i = 1'b0;
  endtask

  task automatic dirty_eviction();
    access(1'b1, params_pkg::WORD, 32'h224, 32'hcafef00d);
    ref_store(20'h224, 4, 32'hcafef00d);
    access(1'b0, params_pkg::WORD, 32'h40224, 0);
    check("evict data", ref_load(20'h40224, 4), r_data);
    check("evict addr", 32'h220, last_wr_addr);
    check("evict line", 32'hcafef00d, last_wr_data[63:32]);
    check("evict before refill", 1, last_wr_seq < last_rd_seq);
    check("refill addr", 32'h40220, last_rd_addr);
  endtask

  task automatic cache_flush();
    int wr_before;
    int t;
    int bad;
    access(1'b1, params_pkg::WORD, 32'h300, 32'h11223344);
    ref_store(20'h300, 4, 32'h11223344);
    access(1'b1, params_pkg::HALF, 32'h316, 32'h5566);
    ref_store(20'h316, 2, 32'h5566);
    access(1'b1, params_pkg::BYTE, 32'h33b, 32'h77);
    ref_store(20'h33b, 1, 32'h77);
    wr_before = wr_count;
    @(negedge clk_i);
    flush_req_i = 1'b1;
    @(negedge clk_i);
    flush_req_i = 1'b0;
    t = 0;
    while (!flush_done_o && t < 300) begin
      @(negedge clk_i);
      t++;
    end
    if (!flush_done_o) begin
      $display("Timeout: cache flush did not complete");
      timeouts++;
    end
    check("flush writes", 3, wr_count - wr_before);
    bad = 0;
    for (int a = 0; a < MEM_BYTES; a++) if (mem[a] !== ref_mem[a]) bad++;
    check("flush memory mismatches", 0, bad);
    access(1'b0, params_pkg::WORD, 32'h300, 0);
    check("flush line valid", 0, r_cyc);
  endtask

  task automatic pipeline_flush();
    int t;
    int wb_seen;
    int walks_before;
    vm_en_i = 1'b1;
    @(negedge clk_i);
    valid_i = 1'b1;
    is_load_i = 1'b1;
    access_size_i = params_pkg::WORD;
    alu_result_i = 32'h7000;  // PPN 0x17
    #1;
    check("pipeline_flush stall", 1, stall_o);
    @(negedge clk_i);
    flush_i = 1'b1;
    valid_i = 1'b0;
    is_load_i = 1'b0;
    @(negedge clk_i);
    flush_i = 1'b0;
    t = 0;
    wb_seen = 0;
    #1;
    while (stall_o && t < 300) begin
      if (wb_valid_o) wb_seen++;
      @(negedge clk_i);
      #1;
      t++;
    end
    if (stall_o) begin
      $display("Timeout: stage stayed stalled after pipeline flush");
      timeouts++;
    end
    if (wb_valid_o) wb_seen++;  // Cycle where the refill lands
    check("pipeline_flush no wb", 0, wb_seen);
    walks_before = walks;
    access(1'b0, params_pkg::WORD, 32'h7000, 0);
    check("pipeline_flush rewalk", 1, walks > walks_before);
    check("pipeline_flush data", ref_load(20'h17000, 4), r_data);
    vm_en_i = 1'b0;
  endtask

  initial begin
    rst_i = 1'b0;
    vm_en_i = 1'b0;
    trap_bypass_mmu_i = 1'b0;
    flush_i = 1'b0;
    valid_i = 1'b0;
    is_load_i = 1'b0;
    is_store_i = 1'b0;
    reg_wr_en_i = 1'b0;
    access_size_i = params_pkg::WORD;
    alu_result_i = '0;
    rs2_data_i = '0;
    wr_reg_i = 5'd7;
    satp_data_i = '0;
    mem_gnt_i = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_write_done_i = 1'b0;
    mem_line_data_i = '0;
    flush_req_i = 1'b0;
    for (int a = 0; a < MEM_BYTES; a++) begin
      mem[a] = fill_byte(a);
      ref_mem[a] = fill_byte(a);
    end
    for (int p = 0; p < 256; p++) present[p] = (p == 8'h13 || p == 8'h17);
    repeat (4) @(negedge clk_i);
    rst_i = 1'b1;
    bare_load();
    store_sizes();
    translate_and_fault();
    dirty_eviction();
    cache_flush();
    pipeline_flush();
    $display("Check errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
